//--- source/multicore_cfg.svh
`ifndef MULTICORE_CFG_SVH
`define MULTICORE_CFG_SVH

// --------------------------------------------------
// Array size and timing
// --------------------------------------------------
`define N_CORES 4  // Neuron cores in the array.
`define N_TAPS 4   // Samples per input vector.
`define STAGGER 9  // Cycles between core releases.

// --------------------------------------------------
// Datapath widths
// --------------------------------------------------
`define SAMPLE_W 19
`define WEIGHT_W 12
`define RESULT_W 28  // Rectified output, unsigned.

`endif

//--- source/multicore_pkg.sv
`include "multicore_cfg.svh"

package multicore_pkg;

	// Signed fixed-point operands.
	typedef logic signed [`SAMPLE_W-1:0] sample_t;
	typedef logic signed [`WEIGHT_W-1:0] weight_t;
	typedef logic signed [`SAMPLE_W+`WEIGHT_W-1:0] prod_t;

	// Room for N_TAPS full-scale products.
	typedef logic signed [`SAMPLE_W+`WEIGHT_W+$clog2(`N_TAPS)-1:0] acc_t;

	typedef logic [`RESULT_W-1:0] result_t;

	typedef logic [$clog2(`N_CORES)-1:0] core_idx_t;
	typedef logic [$clog2(`N_TAPS)-1:0] tap_idx_t;

	typedef enum logic [1:0] {
		seq_hold,
		seq_release,
		seq_done
	} seq_state_t;

endpackage

//--- source/core_link_if.sv
`timescale 1ns/10ps

// One core's result on its way to the arbiter.
interface core_link_if;
	import multicore_pkg::*;

	logic valid;
	logic ready;
	result_t result;
	logic saturated;  // Result was clipped at the top.

	modport core (
		output valid,
		output result,
		output saturated,
		input ready
	);

	modport arbiter (
		input valid,
		input result,
		input saturated,
		output ready
	);
endinterface

//--- source/reset_sequencer.sv
`timescale 1ns/10ps
`include "multicore_cfg.svh"

module reset_sequencer (
	input logic clk,
	input logic rst,
	output logic [`N_CORES-1:0] core_run,
	output logic all_up
);
	import multicore_pkg::*;

	localparam int CNT_W = $clog2(`STAGGER + 1);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`STAGGER - 1);

	seq_state_t state;
	logic [CNT_W-1:0] cnt;
	core_idx_t ptr;  // Next core to release.

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= seq_hold;
			cnt <= '0;
			ptr <= '0;
			core_run <= '0;
			all_up <= 1'b0;
		end else begin
			case (state)
				seq_hold,
				seq_release: begin
					state <= seq_release;
					if (cnt == CNT_LAST) begin
						cnt <= '0;
						core_run[ptr] <= 1'b1;
						ptr <= ptr + 1'b1;
						if (ptr == core_idx_t'(`N_CORES - 1)) begin
							state <= seq_done;  // Last core is up.
							all_up <= 1'b1;
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				seq_done: begin
					all_up <= 1'b1;
				end
				default: state <= seq_hold;
			endcase
		end
	end

	// A released core stays released until the next reset.
	a_run_no_fall: assert property (@(posedge clk) disable iff (rst)
		!$past(rst) |-> (($past(core_run) & ~core_run) == '0));

endmodule

//--- source/neuron_core.sv
`timescale 1ns/10ps
`include "multicore_cfg.svh"

module neuron_core #(
	parameter int CORE_ID = 0
) (
	input logic clk,
	input logic rst,
	input logic run,
	input logic take,
	input multicore_pkg::sample_t sample,
	output logic sample_ready,
	input logic wt_valid,
	input multicore_pkg::core_idx_t wt_core,
	input multicore_pkg::tap_idx_t wt_tap,
	input multicore_pkg::weight_t wt_data,
	core_link_if.core link
);
	import multicore_pkg::*;

	localparam int ACC_W = $bits(acc_t);
	localparam tap_idx_t LAST_TAP = tap_idx_t'(`N_TAPS - 1);

	logic core_rst;
	weight_t weights [`N_TAPS];
	tap_idx_t tap_cnt;
	acc_t acc;
	prod_t prod;
	acc_t sum;
	result_t clipped;
	logic clip_hit;
	logic last_tap;
	logic res_valid;
	result_t res_data;
	logic res_sat;

	assign core_rst = rst | ~run;  // Held down until the sequencer lets go.

	// --------------------------------------------------
	// Weight store
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (wt_valid && wt_core == core_idx_t'(CORE_ID)) begin
			weights[wt_tap] <= wt_data;
		end
	end

	// --------------------------------------------------
	// Multiply-accumulate
	// --------------------------------------------------
	assign last_tap = (tap_cnt == LAST_TAP);
	assign prod = sample * weights[tap_cnt];
	assign sum = acc + prod;

	always_ff @(posedge clk) begin
		if (core_rst) begin
			tap_cnt <= '0;
			acc <= '0;
		end else if (take) begin
			if (last_tap) begin
				tap_cnt <= '0;  // Sum goes to the result register.
				acc <= '0;
			end else begin
				tap_cnt <= tap_cnt + 1'b1;
				acc <= sum;
			end
		end
	end

	// Rectify, then clip to the result range.
	always_comb begin
		clip_hit = 1'b0;
		if (sum[ACC_W-1]) begin
			clipped = '0;
		end else if (|sum[ACC_W-2:`RESULT_W]) begin
			clipped = '1;
			clip_hit = 1'b1;
		end else begin
			clipped = sum[`RESULT_W-1:0];
		end
	end

	// --------------------------------------------------
	// Result register
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (core_rst) begin
			res_valid <= 1'b0;
		end else if (take && last_tap) begin
			res_valid <= 1'b1;
		end else if (link.ready) begin
			res_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take && last_tap) begin
			res_data <= clipped;
			res_sat <= clip_hit;
		end
	end

	// Next vector may fill up to its last tap while the result waits.
	assign sample_ready = ~(res_valid & last_tap);

	assign link.valid = res_valid;
	assign link.result = res_data;
	assign link.saturated = res_sat;

	a_take_ready: assert property (@(posedge clk) disable iff (core_rst)
		take |-> sample_ready);

	a_link_hold: assert property (@(posedge clk) disable iff (core_rst)
		link.valid && !link.ready |=> link.valid && $stable(link.result)
			&& $stable(link.saturated));

endmodule

//--- source/result_arbiter.sv
`timescale 1ns/10ps
`include "multicore_cfg.svh"

module result_arbiter (
	input logic clk,
	input logic rst,
	core_link_if.arbiter links [`N_CORES],
	output logic out_valid,
	input logic out_ready,
	output multicore_pkg::result_t out_data,
	output logic out_saturated,
	output multicore_pkg::core_idx_t out_core
);
	import multicore_pkg::*;

	logic [`N_CORES-1:0] link_valid;
	logic [`N_CORES-1:0] link_sat;
	logic [`N_CORES-1:0] link_ready;
	result_t link_result [`N_CORES];
	core_idx_t pick;
	logic pick_any;
	logic load;

	for (genvar i = 0; i < `N_CORES; i++) begin : g_link
		assign link_valid[i] = links[i].valid;
		assign link_result[i] = links[i].result;
		assign link_sat[i] = links[i].saturated;
		assign links[i].ready = link_ready[i];
	end

	// --------------------------------------------------
	// Fixed priority, lowest index wins
	// --------------------------------------------------
	always_comb begin
		pick = '0;
		pick_any = 1'b0;
		for (int i = `N_CORES - 1; i >= 0; i--) begin
			if (link_valid[i]) begin
				pick = core_idx_t'(i);
				pick_any = 1'b1;
			end
		end
	end

	assign load = pick_any & (~out_valid | out_ready);  // Empty or draining.

	always_comb begin
		link_ready = '0;
		if (load) begin
			link_ready[pick] = 1'b1;
		end
	end

	// --------------------------------------------------
	// Output register
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else if (load) begin
			out_valid <= 1'b1;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			out_data <= link_result[pick];
			out_saturated <= link_sat[pick];
			out_core <= pick;
		end
	end

	a_out_stall: assert property (@(posedge clk) disable iff (rst)
		out_valid && !out_ready |=> out_valid && $stable(out_data)
			&& $stable(out_core) && $stable(out_saturated));

endmodule

//--- source/multicore.sv
`timescale 1ns/10ps
`include "multicore_cfg.svh"

module multicore (
	input logic clk,
	input logic rst,

	// Sample stream, broadcast to all cores.
	input logic in_valid,
	output logic in_ready,
	input multicore_pkg::sample_t in_data,

	// Weight writes, always accepted.
	input logic wt_valid,
	input multicore_pkg::core_idx_t wt_core,
	input multicore_pkg::tap_idx_t wt_tap,
	input multicore_pkg::weight_t wt_data,

	// Tagged result stream.
	output logic out_valid,
	input logic out_ready,
	output multicore_pkg::result_t out_data,
	output logic out_saturated,
	output multicore_pkg::core_idx_t out_core
);

	logic [`N_CORES-1:0] core_run;
	logic [`N_CORES-1:0] sample_ready;
	logic all_up;
	logic take;

	core_link_if links [`N_CORES] ();

	reset_sequencer i_seq (
		.clk (clk),
		.rst (rst),
		.core_run (core_run),
		.all_up (all_up)
	);

	// Every core must be up and able to take the sample.
	assign in_ready = all_up & (&sample_ready);
	assign take = in_valid & in_ready;

	// --------------------------------------------------
	// Neuron cores
	// --------------------------------------------------
	for (genvar c = 0; c < `N_CORES; c++) begin : g_core
		neuron_core #(
			.CORE_ID (c)
		) i_core (
			.clk (clk),
			.rst (rst),
			.run (core_run[c]),
			.take (take),
			.sample (in_data),
			.sample_ready (sample_ready[c]),
			.wt_valid (wt_valid),
			.wt_core (wt_core),
			.wt_tap (wt_tap),
			.wt_data (wt_data),
			.link (links[c])
		);
	end

	result_arbiter i_arb (
		.clk (clk),
		.rst (rst),
		.links (links),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data (out_data),
		.out_saturated (out_saturated),
		.out_core (out_core)
	);

endmodule

//--- verification/multicore_tb.sv
`timescale 1ns/10ps
`include "multicore_cfg.svh"

module multicore_tb;
	import multicore_pkg::*;

	localparam int RELEASE = `N_CORES * `STAGGER;
	localparam int VECTORS = 20;
	localparam int STALL_CYCLES = 16;  // Budget per vector for random out_ready.
	localparam int LIMIT = 2 * (RELEASE + VECTORS * (`N_TAPS + `N_CORES + STALL_CYCLES));
	localparam longint RESULT_MAX = (longint'(1) << `RESULT_W) - 1;

	logic clk;
	logic rst;
	logic in_valid;
	logic in_ready;
	sample_t in_data;
	logic wt_valid;
	core_idx_t wt_core;
	tap_idx_t wt_tap;
	weight_t wt_data;
	logic out_valid;
	logic out_ready = 1'b1;
	result_t out_data;
	logic out_saturated;
	core_idx_t out_core;

	weight_t model_w [`N_CORES][`N_TAPS];
	sample_t vec [`N_TAPS];
	result_t exp_data [256];  // Expected results in output order.
	logic exp_sat [256];
	core_idx_t exp_core [256];
	int wr_ptr;
	int rd_ptr;
	result_t head_data;
	logic head_sat;
	core_idx_t head_core;
	logic head_ok;
	logic [31:0] rnd_state;
	logic [31:0] ready_state = 32'd8211;
	logic stall_mode;
	int since_rst;
	int cycles;
	int errors;
	int errs_before;
	int tests_run;
	int tests_failed;

	multicore i_dut (
		.clk (clk),
		.rst (rst),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.in_data (in_data),
		.wt_valid (wt_valid),
		.wt_core (wt_core),
		.wt_tap (wt_tap),
		.wt_data (wt_data),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data (out_data),
		.out_saturated (out_saturated),
		.out_core (out_core)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] lcg(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [31:0] next_random();
		rnd_state = lcg(rnd_state);
		return rnd_state;
	endfunction

	task automatic log_mismatch(input string msg);
		errors++;
		$display("Mismatch at %0t: %s", $time, msg);
	endtask

	task automatic fail_check(input string msg);
		errors++;
		$display("%s at %0t", msg, $time);
	endtask

	// --------------------------------------------------
	// Reference model and bookkeeping
	// --------------------------------------------------
	assign head_ok = rd_ptr < wr_ptr;
	assign head_data = exp_data[rd_ptr];
	assign head_sat = exp_sat[rd_ptr];
	assign head_core = exp_core[rd_ptr];

	always @(posedge clk) begin
		if (rst) begin
			rd_ptr <= 0;
			since_rst <= 0;
		end else begin
			if (out_valid && out_ready) rd_ptr <= rd_ptr + 1;
			if (since_rst < 1000) since_rst <= since_rst + 1;
		end
	end

	always @(negedge clk) begin
		if (stall_mode) begin
			ready_state = lcg(ready_state);
			out_ready = ready_state[16];
		end else begin
			out_ready = 1'b1;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("Timeout after %0d cycles, outputs stopped arriving", cycles);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// --------------------------------------------------
	// Checks
	// --------------------------------------------------
	a_reset_hold: assert property (@(posedge clk) disable iff (rst)
		since_rst < RELEASE |-> !in_ready)
		else fail_check("in_ready rose before all cores were released");

	a_reset_up: assert property (@(posedge clk) disable iff (rst)
		since_rst == RELEASE |-> in_ready)
		else fail_check("in_ready stayed low after the last release");

	a_idle: assert property (@(posedge clk) $fell(rst) |-> !out_valid && !in_ready)
		else fail_check("Stream not idle right after reset");

	a_expected: assert property (@(posedge clk) disable iff (rst)
		out_valid && out_ready |-> head_ok)
		else fail_check("Output arrived with no result expected");

	a_value: assert property (@(posedge clk) disable iff (rst)
		out_valid && out_ready && head_ok |-> out_data == head_data
			&& out_core == head_core && out_saturated == head_sat)
		else log_mismatch("output differs from the model");

	a_stall: assert property (@(posedge clk) disable iff (rst)
		out_valid && !out_ready |=> out_valid && $stable(out_data)
			&& $stable(out_core) && $stable(out_saturated))
		else log_mismatch("output changed under stall");

	a_sat_max: assert property (@(posedge clk) disable iff (rst)
		out_valid && out_saturated |-> longint'(out_data) == RESULT_MAX)
		else log_mismatch("saturated output not at maximum");

	// --------------------------------------------------
	// Stimulus tasks, all entered on a falling edge
	// --------------------------------------------------
	task automatic write_weight(input int c, input int t, input weight_t w);
		wt_valid = 1'b1;
		wt_core = core_idx_t'(c);
		wt_tap = tap_idx_t'(t);
		wt_data = w;
		model_w[c][t] = w;
		@(negedge clk);
		wt_valid = 1'b0;
	endtask

	task automatic load_core(input int c);
		for (int t = 0; t < `N_TAPS; t++) begin
			write_weight(c, t, weight_t'(next_random() >> 13));
		end
	endtask

	task automatic predict();
		longint acc;
		for (int c = 0; c < `N_CORES; c++) begin
			acc = 0;
			for (int t = 0; t < `N_TAPS; t++) begin
				acc += longint'(model_w[c][t]) * longint'(vec[t]);
			end
			exp_core[wr_ptr] = core_idx_t'(c);
			exp_sat[wr_ptr] = acc > RESULT_MAX;
			if (acc < 0) exp_data[wr_ptr] = '0;
			else if (acc > RESULT_MAX) exp_data[wr_ptr] = '1;
			else exp_data[wr_ptr] = result_t'(acc);
			wr_ptr++;
		end
	endtask

	task automatic send_vector();
		predict();
		for (int t = 0; t < `N_TAPS; t++) begin
			in_valid = 1'b1;
			in_data = vec[t];
			while (!in_ready) @(negedge clk);  // in_ready is settled by now.
			@(negedge clk);
		end
		in_valid = 1'b0;
	endtask

	task automatic send_random(input int count);
		for (int n = 0; n < count; n++) begin
			for (int t = 0; t < `N_TAPS; t++) vec[t] = sample_t'(next_random() >> 7);
			send_vector();
		end
	endtask

	task automatic drain();
		while (rd_ptr < wr_ptr) @(negedge clk);
		@(negedge clk);
	endtask

	task automatic report_test(input string name);
		tests_run++;
		if (errors != errs_before) begin
			tests_failed++;
			$display("Test %0d, %s: failed, %0d errors", tests_run, name, errors - errs_before);
		end else begin
			$display("Test %0d, %s: ok", tests_run, name);
		end
		errs_before = errors;
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		in_valid = 1'b0;
		in_data = '0;
		wt_valid = 1'b0;
		wt_core = '0;
		wt_tap = '0;
		wt_data = '0;
		stall_mode = 1'b0;
		rnd_state = 32'd8211;
		repeat (10) @(negedge clk);
		rst = 1'b0;
		while (!in_ready) @(negedge clk);
		report_test("reset sequencing");

		for (int c = 0; c < `N_CORES; c++) load_core(c);
		send_random(6);
		drain();
		report_test("dot products");

		// Most negative weight everywhere; sign of the samples picks the clip side.
		for (int c = 0; c < `N_CORES; c++) begin
			for (int t = 0; t < `N_TAPS; t++) begin
				write_weight(c, t, weight_t'(1 << (`WEIGHT_W - 1)));
			end
		end
		for (int t = 0; t < `N_TAPS; t++) vec[t] = sample_t'((1 << (`SAMPLE_W - 1)) - 1);
		send_vector();
		for (int t = 0; t < `N_TAPS; t++) vec[t] = sample_t'(1 << (`SAMPLE_W - 1));
		send_vector();
		drain();
		report_test("rectify and saturate");

		for (int c = 0; c < `N_CORES; c++) load_core(c);
		stall_mode = 1'b1;
		send_random(8);
		drain();
		stall_mode = 1'b0;
		report_test("back-pressure");

		load_core(`N_CORES / 2);
		send_random(4);
		drain();
		report_test("per-core weights");

		repeat (5) @(negedge clk);
		assert (rd_ptr == wr_ptr) else begin
			errors++;
			$display("Lost or extra results: %0d expected, %0d seen", wr_ptr, rd_ptr);
		end
		$display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

//--- multicore.f
+incdir+source
source/multicore_pkg.sv
source/core_link_if.sv
source/reset_sequencer.sv
source/neuron_core.sv
source/result_arbiter.sv
source/multicore.sv
verification/multicore_tb.sv

//--- Makefile
SIM = verilator
FLAGS = --binary --timing --assert
TOP = multicore_tb
FILELIST = multicore.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
